// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(BUILD_DIR)

// ==== design/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  alu_sel_t;

    // ALU operation selects.
    localparam alu_sel_t SEL_OR    = 3'd0;
    localparam alu_sel_t SEL_LUI   = 3'd1;
    localparam alu_sel_t SEL_AUIPC = 3'd2;
    localparam alu_sel_t SEL_ADD   = 3'd3; // Address generation for LW and SW.

    // Major opcodes of the decoded subset.
    localparam logic [6:0] OP_OPIMM = 7'b0010011;
    localparam logic [6:0] OP_OP    = 7'b0110011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    // funct3 values that select OR and word access.
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_WORD = 3'b010;

endpackage

`default_nettype wire

// ==== design/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter int unsigned DMEM_WORDS = 64
) (
    input  wire                 clk_i,
    input  wire                 rst_i,
    input  wire                 inst_valid_i,
    input  wire cpu_pkg::word_t inst_i,
    output logic                stall_o,
    output logic                wb_we_o,
    output cpu_pkg::reg_addr_t  wb_addr_o,
    output cpu_pkg::word_t      wb_data_o
);

    logic               id_valid;
    cpu_pkg::word_t     id_pc;
    cpu_pkg::word_t     id_inst;
    logic               re1;
    logic               re2;
    cpu_pkg::reg_addr_t raddr1;
    cpu_pkg::reg_addr_t raddr2;
    cpu_pkg::word_t     rdata1;
    cpu_pkg::word_t     rdata2;
    cpu_pkg::alu_sel_t  id_alusel;
    cpu_pkg::word_t     id_opr1;
    cpu_pkg::word_t     id_opr2;
    cpu_pkg::word_t     id_imm;
    cpu_pkg::word_t     id_pc_ex;
    cpu_pkg::reg_addr_t id_wd;
    logic               id_wreg;
    logic               id_load;
    logic               id_store;
    logic               ex_we;
    cpu_pkg::reg_addr_t ex_wd;
    cpu_pkg::word_t     ex_result;
    cpu_pkg::word_t     ex_store_data;
    logic               ex_load;
    logic               ex_store;
    logic               mem_we;
    cpu_pkg::reg_addr_t mem_wd;
    cpu_pkg::word_t     mem_data;

    if_stage u_if (
        .clk_i(clk_i), .rst_i(rst_i), .inst_valid_i(inst_valid_i), .inst_i(inst_i),
        .stall_i(stall_o), .id_valid_o(id_valid), .id_pc_o(id_pc), .id_inst_o(id_inst)
    );

    id_stage u_id (
        .valid_i(id_valid), .pc_i(id_pc), .inst_i(id_inst),
        .reg1_read_o(re1), .reg2_read_o(re2), .reg1_addr_o(raddr1), .reg2_addr_o(raddr2),
        .reg1_data_i(rdata1), .reg2_data_i(rdata2),
        .alusel_o(id_alusel), .opr1_o(id_opr1), .opr2_o(id_opr2), .imm_o(id_imm),
        .pc_o(id_pc_ex), .wd_o(id_wd), .wreg_o(id_wreg), .load_o(id_load), .store_o(id_store),
        .ex_we_i(ex_we), .ex_wd_i(ex_wd), .ex_data_i(ex_result), .ex_load_i(ex_load),
        .mem_we_i(mem_we), .mem_wd_i(mem_wd), .mem_data_i(mem_data), .stall_o(stall_o)
    );

    regfile u_rf (
        .clk_i(clk_i), .rst_i(rst_i), .re1_i(re1), .re2_i(re2),
        .raddr1_i(raddr1), .raddr2_i(raddr2), .rdata1_o(rdata1), .rdata2_o(rdata2),
        .we_i(wb_we_o), .waddr_i(wb_addr_o), .wdata_i(wb_data_o)
    );

    ex_stage u_ex (
        .clk_i(clk_i), .rst_i(rst_i), .stall_i(stall_o), .alusel_i(id_alusel),
        .opr1_i(id_opr1), .opr2_i(id_opr2), .imm_i(id_imm), .pc_i(id_pc_ex), .wd_i(id_wd),
        .wreg_i(id_wreg), .load_i(id_load), .store_i(id_store),
        .we_o(ex_we), .wd_o(ex_wd), .result_o(ex_result), .store_data_o(ex_store_data),
        .load_o(ex_load), .store_o(ex_store)
    );

    mem_stage #(.DMEM_WORDS(DMEM_WORDS)) u_mem (
        .clk_i(clk_i), .rst_i(rst_i), .we_i(ex_we), .wd_i(ex_wd), .result_i(ex_result),
        .store_data_i(ex_store_data), .load_i(ex_load), .store_i(ex_store),
        .fwd_we_o(mem_we), .fwd_wd_o(mem_wd), .fwd_data_o(mem_data),
        .wb_we_o(wb_we_o), .wb_addr_o(wb_addr_o), .wb_data_o(wb_data_o)
    );

endmodule

`default_nettype wire

// ==== design/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  wire                     clk_i,
    input  wire                     rst_i,
    input  wire                     stall_i,
    input  wire cpu_pkg::alu_sel_t  alusel_i,
    input  wire cpu_pkg::word_t     opr1_i,
    input  wire cpu_pkg::word_t     opr2_i,
    input  wire cpu_pkg::word_t     imm_i,
    input  wire cpu_pkg::word_t     pc_i,
    input  wire cpu_pkg::reg_addr_t wd_i,
    input  wire                     wreg_i,
    input  wire                     load_i,
    input  wire                     store_i,
    output logic                    we_o,
    output cpu_pkg::reg_addr_t      wd_o,
    output cpu_pkg::word_t          result_o,
    output cpu_pkg::word_t          store_data_o,
    output logic                    load_o,
    output logic                    store_o
);

    cpu_pkg::alu_sel_t alusel_q;
    cpu_pkg::word_t    opr1_q;
    cpu_pkg::word_t    opr2_q;
    cpu_pkg::word_t    imm_q;
    cpu_pkg::word_t    pc_q;

    // A stall in ID turns this slot into a bubble.
    always_ff @(posedge clk_i) begin
        if (rst_i || stall_i) begin
            we_o    <= 1'b0;
            load_o  <= 1'b0;
            store_o <= 1'b0;
        end else begin
            we_o    <= wreg_i;
            load_o  <= load_i;
            store_o <= store_i;
        end
    end

    always_ff @(posedge clk_i) begin
        alusel_q <= alusel_i;
        opr1_q   <= opr1_i;
        opr2_q   <= opr2_i;
        imm_q    <= imm_i;
        pc_q     <= pc_i;
        wd_o     <= wd_i;
    end

    always_comb begin
        case (alusel_q)
            cpu_pkg::SEL_OR:    result_o = opr1_q | opr2_q;
            cpu_pkg::SEL_LUI:   result_o = imm_q;
            cpu_pkg::SEL_AUIPC: result_o = pc_q + imm_q;
            cpu_pkg::SEL_ADD:   result_o = opr1_q + imm_q;
            default:            result_o = '0;
        endcase
    end

    assign store_data_o = opr2_q;

endmodule

`default_nettype wire

// ==== design/id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  wire                     valid_i,
    input  wire cpu_pkg::word_t     pc_i,
    input  wire cpu_pkg::word_t     inst_i,
    output logic                    reg1_read_o,
    output logic                    reg2_read_o,
    output cpu_pkg::reg_addr_t      reg1_addr_o,
    output cpu_pkg::reg_addr_t      reg2_addr_o,
    input  wire cpu_pkg::word_t     reg1_data_i,
    input  wire cpu_pkg::word_t     reg2_data_i,
    output cpu_pkg::alu_sel_t       alusel_o,
    output cpu_pkg::word_t          opr1_o,
    output cpu_pkg::word_t          opr2_o,
    output cpu_pkg::word_t          imm_o,
    output cpu_pkg::word_t          pc_o,
    output cpu_pkg::reg_addr_t      wd_o,
    output logic                    wreg_o,
    output logic                    load_o,
    output logic                    store_o,
    input  wire                     ex_we_i,
    input  wire cpu_pkg::reg_addr_t ex_wd_i,
    input  wire cpu_pkg::word_t     ex_data_i,
    input  wire                     ex_load_i,
    input  wire                     mem_we_i,
    input  wire cpu_pkg::reg_addr_t mem_wd_i,
    input  wire cpu_pkg::word_t     mem_data_i,
    output logic                    stall_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       dec_re1;
    logic       dec_re2;
    logic       dec_wreg;
    logic       dec_load;
    logic       dec_store;
    logic       use_imm2;
    logic       hazard1;
    logic       hazard2;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign reg1_addr_o = inst_i[19:15];
    assign reg2_addr_o = inst_i[24:20];
    assign wd_o        = inst_i[11:7];
    assign pc_o        = pc_i;

    always_comb begin
        alusel_o  = cpu_pkg::SEL_OR;
        imm_o     = '0;
        dec_re1   = 1'b0;
        dec_re2   = 1'b0;
        dec_wreg  = 1'b0;
        dec_load  = 1'b0;
        dec_store = 1'b0;
        use_imm2  = 1'b0;
        case (opcode)
            cpu_pkg::OP_OPIMM: if (funct3 == cpu_pkg::F3_OR) begin
                dec_re1  = 1'b1;
                dec_wreg = 1'b1;
                use_imm2 = 1'b1;
                imm_o    = {{20{inst_i[31]}}, inst_i[31:20]};
            end
            cpu_pkg::OP_OP: if (funct3 == cpu_pkg::F3_OR && funct7 == 7'd0) begin
                dec_re1  = 1'b1;
                dec_re2  = 1'b1;
                dec_wreg = 1'b1;
            end
            cpu_pkg::OP_LUI: begin
                alusel_o = cpu_pkg::SEL_LUI;
                dec_wreg = 1'b1;
                imm_o    = {inst_i[31:12], 12'd0};
            end
            cpu_pkg::OP_AUIPC: begin
                alusel_o = cpu_pkg::SEL_AUIPC;
                dec_wreg = 1'b1;
                imm_o    = {inst_i[31:12], 12'd0};
            end
            cpu_pkg::OP_LOAD: if (funct3 == cpu_pkg::F3_WORD) begin
                alusel_o = cpu_pkg::SEL_ADD;
                dec_re1  = 1'b1;
                dec_wreg = 1'b1;
                dec_load = 1'b1;
                imm_o    = {{20{inst_i[31]}}, inst_i[31:20]};
            end
            cpu_pkg::OP_STORE: if (funct3 == cpu_pkg::F3_WORD) begin
                alusel_o  = cpu_pkg::SEL_ADD;
                dec_re1   = 1'b1;
                dec_re2   = 1'b1; // rs2 carries the store data.
                dec_store = 1'b1;
                imm_o     = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
            end
            default: ;
        endcase
    end

    assign reg1_read_o = valid_i & dec_re1;
    assign reg2_read_o = valid_i & dec_re2;
    assign wreg_o      = valid_i & dec_wreg & (wd_o != '0);
    assign load_o      = valid_i & dec_load;
    assign store_o     = valid_i & dec_store;

    // Newest producer wins; the register file bypass covers writeback.
    function automatic cpu_pkg::word_t fwd_value(input logic en,
                                                 input cpu_pkg::reg_addr_t addr,
                                                 input cpu_pkg::word_t rf_data);
        if (!en || addr == '0) begin
            return '0;
        end
        if (ex_we_i && ex_wd_i == addr) begin
            return ex_data_i;
        end
        if (mem_we_i && mem_wd_i == addr) begin
            return mem_data_i;
        end
        return rf_data;
    endfunction

    always_comb begin
        opr1_o = fwd_value(reg1_read_o, reg1_addr_o, reg1_data_i);
        opr2_o = use_imm2 ? imm_o : fwd_value(reg2_read_o, reg2_addr_o, reg2_data_i);
    end

    // A load in EX has no data yet, so its consumer waits one cycle.
    assign hazard1 = reg1_read_o && reg1_addr_o != '0 && ex_we_i && ex_load_i
                     && ex_wd_i == reg1_addr_o;
    assign hazard2 = reg2_read_o && reg2_addr_o != '0 && ex_we_i && ex_load_i
                     && ex_wd_i == reg2_addr_o;
    assign stall_o = hazard1 | hazard2;

endmodule

`default_nettype wire

// ==== design/if_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module if_stage (
    input  wire                  clk_i,
    input  wire                  rst_i,
    input  wire                  inst_valid_i,
    input  wire cpu_pkg::word_t  inst_i,
    input  wire                  stall_i,
    output logic                 id_valid_o,
    output cpu_pkg::word_t       id_pc_o,
    output cpu_pkg::word_t       id_inst_o
);

    cpu_pkg::word_t pc_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            id_valid_o <= 1'b0;
            pc_q       <= '0;
        end else if (!stall_i) begin
            id_valid_o <= inst_valid_i; // An idle input becomes a bubble.
            if (inst_valid_i) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i && inst_valid_i) begin
            id_pc_o   <= pc_q;
            id_inst_o <= inst_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
    parameter int unsigned DMEM_WORDS = 64
) (
    input  wire                     clk_i,
    input  wire                     rst_i,
    input  wire                     we_i,
    input  wire cpu_pkg::reg_addr_t wd_i,
    input  wire cpu_pkg::word_t     result_i,
    input  wire cpu_pkg::word_t     store_data_i,
    input  wire                     load_i,
    input  wire                     store_i,
    output logic                    fwd_we_o,
    output cpu_pkg::reg_addr_t      fwd_wd_o,
    output cpu_pkg::word_t          fwd_data_o,
    output logic                    wb_we_o,
    output cpu_pkg::reg_addr_t      wb_addr_o,
    output cpu_pkg::word_t          wb_data_o
);

    localparam int unsigned AW = $clog2(DMEM_WORDS);

    logic           load_q;
    logic           store_q;
    cpu_pkg::word_t result_q;
    cpu_pkg::word_t store_data_q;
    logic [AW-1:0]  ram_addr;
    cpu_pkg::word_t ram_q [DMEM_WORDS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fwd_we_o <= 1'b0;
            load_q   <= 1'b0;
            store_q  <= 1'b0;
        end else begin
            fwd_we_o <= we_i;
            load_q   <= load_i;
            store_q  <= store_i;
        end
    end

    always_ff @(posedge clk_i) begin
        fwd_wd_o     <= wd_i;
        result_q     <= result_i;
        store_data_q <= store_data_i;
    end

    assign ram_addr = result_q[AW+1:2]; // Word index wraps at the RAM depth.

    initial begin
        for (int i = 0; i < DMEM_WORDS; i++) begin
            ram_q[i] = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (store_q) begin
            ram_q[ram_addr] <= store_data_q;
        end
    end

    assign fwd_data_o = load_q ? ram_q[ram_addr] : result_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_we_o <= 1'b0;
        end else begin
            wb_we_o <= fwd_we_o;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_addr_o <= fwd_wd_o;
        wb_data_o <= fwd_data_o;
    end

endmodule

`default_nettype wire

// ==== design/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire                     clk_i,
    input  wire                     rst_i,
    input  wire                     re1_i,
    input  wire                     re2_i,
    input  wire cpu_pkg::reg_addr_t raddr1_i,
    input  wire cpu_pkg::reg_addr_t raddr2_i,
    output cpu_pkg::word_t          rdata1_o,
    output cpu_pkg::word_t          rdata2_o,
    input  wire                     we_i,
    input  wire cpu_pkg::reg_addr_t waddr_i,
    input  wire cpu_pkg::word_t     wdata_i
);

    cpu_pkg::word_t regs_q [32];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Same-cycle write is passed straight to the reader.
    always_comb begin
        if (!re1_i || raddr1_i == '0) begin
            rdata1_o = '0;
        end else if (we_i && waddr_i == raddr1_i) begin
            rdata1_o = wdata_i;
        end else begin
            rdata1_o = regs_q[raddr1_i];
        end
    end

    always_comb begin
        if (!re2_i || raddr2_i == '0) begin
            rdata2_o = '0;
        end else if (we_i && waddr_i == raddr2_i) begin
            rdata2_o = wdata_i;
        end else begin
            rdata2_o = regs_q[raddr2_i];
        end
    end

endmodule

`default_nettype wire

// ==== test/cpu_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_asserts (
    input wire                     clk_i,
    input wire                     rst_i,
    input wire                     stall_i,
    input wire                     wb_we_i,
    input wire cpu_pkg::reg_addr_t wb_addr_i
);

    int fail_count = 0;

    // The load moves on to MEM, so a load-use stall ends after one cycle.
    stall_single: assert property (@(posedge clk_i) disable iff (rst_i) stall_i |=> !stall_i)
        else begin
            fail_count++;
            $error("stall_o stayed high for two consecutive cycles");
        end

    reset_quiet: assert property (@(posedge clk_i)
        (!rst_i && ($past(rst_i) || $past(rst_i, 2) || $past(rst_i, 3))) |-> !wb_we_i)
        else begin
            fail_count++;
            $error("wb_we_o rose within three cycles of reset release");
        end

    no_x0_write: assert property (@(posedge clk_i) disable iff (rst_i)
        wb_we_i |-> wb_addr_i != '0)
        else begin
            fail_count++;
            $error("writeback to x0 was signalled");
        end

endmodule

`default_nettype wire

// ==== test/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;

    logic               clk_i;
    logic               rst_i;
    logic               inst_valid_i;
    cpu_pkg::word_t     inst_i;
    logic               stall_o;
    logic               wb_we_o;
    cpu_pkg::reg_addr_t wb_addr_o;
    cpu_pkg::word_t     wb_data_o;

    string              row_name[$];
    cpu_pkg::word_t     row_inst[$];
    bit                 row_tight[$];
    bit                 row_stall[$];
    bit                 row_wb[$];
    cpu_pkg::reg_addr_t row_rd[$];
    cpu_pkg::word_t     row_val[$];
    cpu_pkg::reg_addr_t seen_addr[$];
    cpu_pkg::word_t     seen_data[$];
    int                 stall_cycles = 0;
    int                 pass_cnt = 0;
    int                 fail_cnt = 0;
    logic [15:0]        lfsr;
    bit                 table_ready = 1'b0;

    cpu_top #(.DMEM_WORDS(64)) uut (
        .clk_i(clk_i), .rst_i(rst_i), .inst_valid_i(inst_valid_i), .inst_i(inst_i),
        .stall_o(stall_o), .wb_we_o(wb_we_o), .wb_addr_o(wb_addr_o), .wb_data_o(wb_data_o)
    );

    bind cpu_top cpu_asserts u_asserts (
        .clk_i(clk_i), .rst_i(rst_i), .stall_i(stall_o), .wb_we_i(wb_we_o),
        .wb_addr_i(wb_addr_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Taps 16, 14, 13 and 11; the new bit enters at the bottom.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic cpu_pkg::word_t enc_ori(input cpu_pkg::reg_addr_t rd,
                                               input cpu_pkg::reg_addr_t rs1,
                                               input logic [11:0] imm);
        return {imm, rs1, 3'b110, rd, 7'b0010011};
    endfunction

    function automatic cpu_pkg::word_t enc_or(input cpu_pkg::reg_addr_t rd,
                                              input cpu_pkg::reg_addr_t rs1,
                                              input cpu_pkg::reg_addr_t rs2);
        return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
    endfunction

    function automatic cpu_pkg::word_t enc_lui(input cpu_pkg::reg_addr_t rd,
                                               input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic cpu_pkg::word_t enc_auipc(input cpu_pkg::reg_addr_t rd,
                                                 input logic [19:0] imm);
        return {imm, rd, 7'b0010111};
    endfunction

    function automatic cpu_pkg::word_t enc_lw(input cpu_pkg::reg_addr_t rd,
                                              input cpu_pkg::reg_addr_t rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic cpu_pkg::word_t enc_sw(input cpu_pkg::reg_addr_t rs2,
                                              input cpu_pkg::reg_addr_t rs1,
                                              input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    task automatic add_row(input string name, input cpu_pkg::word_t inst, input bit tight,
                           input bit stall, input bit wb, input cpu_pkg::reg_addr_t rd,
                           input cpu_pkg::word_t val);
        row_name.push_back(name);
        row_inst.push_back(inst);
        row_tight.push_back(tight);
        row_stall.push_back(stall);
        row_wb.push_back(wb);
        row_rd.push_back(rd);
        row_val.push_back(val);
    endtask

    // Each row gives the name, instruction, back-to-back flag, stall, writeback, rd and value.
    task automatic build_program();
        add_row("ori_small", enc_ori(5'd1, 5'd0, 12'h123), '0, '0, '1, 5'd1, 32'h0000_0123);
        add_row("ori_signext", enc_ori(5'd2, 5'd0, 12'hfff), '0, '0, '1, 5'd2, 32'hffff_ffff);
        add_row("lui", enc_lui(5'd3, 20'habcde), '0, '0, '1, 5'd3, 32'habcd_e000);
        add_row("ori_to_x0", enc_ori(5'd0, 5'd1, 12'h055), '0, '0, '0, 5'd0, 32'h0);
        add_row("ori_upper", enc_ori(5'd4, 5'd3, 12'h0f0), '0, '0, '1, 5'd4, 32'habcd_e0f0);
        add_row("lui_second", enc_lui(5'd5, 20'h12345), '0, '0, '1, 5'd5, 32'h1234_5000);
        add_row("or_ex_fwd", enc_or(5'd6, 5'd5, 5'd1), '1, '0, '1, 5'd6, 32'h1234_5123);
        add_row("or_ex_fwd_chain", enc_or(5'd7, 5'd6, 5'd4), '1, '0, '1, 5'd7, 32'hbbfd_f1f3);
        add_row("ori_mem_src", enc_ori(5'd8, 5'd0, 12'h700), '0, '0, '1, 5'd8, 32'h0000_0700);
        add_row("lui_between", enc_lui(5'd9, 20'h00f00), '1, '0, '1, 5'd9, 32'h00f0_0000);
        add_row("or_mem_fwd", enc_or(5'd10, 5'd8, 5'd1), '1, '0, '1, 5'd10, 32'h0000_0723);
        add_row("auipc_pc44", enc_auipc(5'd11, 20'h00001), '0, '0, '1, 5'd11, 32'h0000_102c);
        add_row("auipc_pc48", enc_auipc(5'd12, 20'hfffff), '0, '0, '1, 5'd12, 32'hffff_f030);
        add_row("ori_base", enc_ori(5'd13, 5'd0, 12'h040), '0, '0, '1, 5'd13, 32'h0000_0040);
        add_row("sw_word16", enc_sw(5'd7, 5'd13, 12'h000), '1, '0, '0, 5'd0, 32'h0);
        add_row("sw_word17", enc_sw(5'd11, 5'd13, 12'h004), '0, '0, '0, 5'd0, 32'h0);
        add_row("lw_word16", enc_lw(5'd14, 5'd13, 12'h000), '0, '0, '1, 5'd14, 32'hbbfd_f1f3);
        add_row("lw_word17", enc_lw(5'd15, 5'd13, 12'h004), '0, '0, '1, 5'd15, 32'h0000_102c);
        add_row("lw_unwritten", enc_lw(5'd16, 5'd13, 12'h008), '0, '0, '1, 5'd16, 32'h0);
        add_row("sw_word15", enc_sw(5'd10, 5'd13, 12'hffc), '0, '0, '0, 5'd0, 32'h0);
        add_row("lw_after_sw", enc_lw(5'd17, 5'd13, 12'hffc), '1, '0, '1, 5'd17, 32'h0000_0723);
        add_row("lw_for_use", enc_lw(5'd18, 5'd13, 12'h000), '0, '0, '1, 5'd18, 32'hbbfd_f1f3);
        add_row("or_load_use", enc_or(5'd19, 5'd18, 5'd10), '1, '1, '1, 5'd19, 32'hbbfd_f7f3);
        add_row("or_after_stall", enc_or(5'd20, 5'd19, 5'd12), '1, '0, '1, 5'd20, 32'hffff_f7f3);
        add_row("lw_for_rs2", enc_lw(5'd21, 5'd13, 12'h004), '0, '0, '1, 5'd21, 32'h0000_102c);
        add_row("or_load_use_rs2", enc_or(5'd22, 5'd1, 5'd21), '1, '1, '1, 5'd22, 32'h0000_112f);
    endtask

    // Holds the inputs until a rising edge with stall_o low takes them.
    task automatic present(input logic valid, input cpu_pkg::word_t inst);
        logic stalled;
        inst_valid_i <= valid;
        inst_i       <= inst;
        stalled = 1'b1;
        while (stalled) begin
            @(negedge clk_i);
            stalled = stall_o;
            @(posedge clk_i);
        end
    endtask

    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (wb_we_o) begin
                seen_addr.push_back(wb_addr_o);
                seen_data.push_back(wb_data_o);
            end
            if (stall_o) begin
                stall_cycles++;
            end
        end
    end

    task automatic check_addr(input string name, input cpu_pkg::reg_addr_t exp,
                              input cpu_pkg::reg_addr_t act, inout bit ok);
        if (act !== exp) begin
            $display("ERR %s: rd expected x%0d, actual x%0d", name, exp, act);
            ok = 1'b0;
        end
    endtask

    task automatic check_data(input string name, input cpu_pkg::word_t exp,
                              input cpu_pkg::word_t act, inout bit ok);
        if (act !== exp) begin
            $display("ERR %s: data expected %h, actual %h", name, exp, act);
            ok = 1'b0;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act, inout bit ok);
        if (act != exp) begin
            $display("ERR %s: count expected %0d, actual %0d", name, exp, act);
            ok = 1'b0;
        end
    endtask

    task automatic report_test(input string name, input bit ok);
        if (ok) begin
            pass_cnt++;
            $display("%s: PASS", name);
        end else begin
            fail_cnt++;
            $display("%s: FAIL", name);
        end
    endtask

    task automatic score_program();
        int wb_pos;
        int expected_stalls;
        bit ok;
        wb_pos = 0;
        expected_stalls = 0;
        for (int i = 0; i < row_name.size(); i++) begin
            ok = 1'b1;
            if (row_stall[i]) begin
                expected_stalls++;
            end
            if (row_wb[i]) begin
                if (wb_pos >= seen_addr.size()) begin
                    $display("%s: no writeback arrived for x%0d", row_name[i], row_rd[i]);
                    ok = 1'b0;
                end else begin
                    check_addr(row_name[i], row_rd[i], seen_addr[wb_pos], ok);
                    check_data(row_name[i], row_val[i], seen_data[wb_pos], ok);
                    wb_pos++;
                end
            end
            report_test(row_name[i], ok);
        end
        ok = 1'b1;
        if (wb_pos < seen_addr.size()) begin
            $display("writeback_count: %0d writebacks came that the program does not make",
                     seen_addr.size() - wb_pos);
            ok = 1'b0;
        end
        report_test("writeback_count", ok);
        ok = 1'b1;
        check_count("load_use_stalls", expected_stalls, stall_cycles, ok);
        report_test("load_use_stalls", ok);
        ok = 1'b1;
        check_count("assertions", 0, uut.u_asserts.fail_count, ok);
        report_test("assertions", ok);
    endtask

    initial begin
        logic [1:0] gap;
        rst_i        <= 1'b1;
        inst_valid_i <= 1'b0;
        inst_i       <= '0;
        lfsr = 16'd64275;
        build_program();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
        for (int i = 0; i < row_name.size(); i++) begin
            lfsr = lfsr_next(lfsr);
            gap[0] = lfsr[0];
            lfsr = lfsr_next(lfsr);
            gap[1] = lfsr[0];
            if (row_tight[i]) begin
                gap = 2'd0; // Forwarding rows need their producer right before them.
            end
            repeat (gap) present(1'b0, inst_i);
            present(1'b1, row_inst[i]);
        end
        inst_valid_i <= 1'b0;
        repeat (5) @(posedge clk_i); // The last writeback shows three edges after acceptance.
        score_program();
        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        int limit_cycles;
        wait (table_ready);
        limit_cycles = 8 * row_name.size() + RESET_CYCLES;
        #(limit_cycles * CLK_PERIOD);
        $display("timeout: the program did not finish within %0d cycles", limit_cycles);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/cpu_pkg.sv
design/if_stage.sv
design/regfile.sv
design/id_stage.sv
design/ex_stage.sv
design/mem_stage.sv
design/cpu_top.sv
test/cpu_asserts.sv
test/cpu_tb.sv
